// ==== test/cache_golden.txt ====
# op addr value: R cpu read, W cpu write, C control read, K control write
# addr and value in hex; value is write data or the expected read result
C 8 00010300
C 6 00000001
C 7 00000000
C c 00000000
C 9 00000000
R 0010 c0de0010
R 0010 c0de0010
R 0450 c0de0450
R 0010 c0de0010
R 0011 c0de0011
C 2 00000001
C 3 00000004
W 0011 11110000
W 0020 22220000
W 0021 22220001
W 0022 22220002
W 0023 22220003
W 0024 22220004
W 0025 22220005
R 0100 c0de0100
R 0011 11110000
R 0022 22220002
R 0022 22220002
C 4 00000001
C 5 00000006
C 0 00000004
C 1 0000000c
K 9 00000000
C 0 00000000
C 1 00000000
R 0022 22220002
K a 00000000
R 0022 22220002
C 2 00000001
C 3 00000001
W 0022 33330000
R 0022 33330000
C 0 00000003
C 1 00000001
C 6 00000001
C 7 00000000

// ==== verilog.f ====
+incdir+hdl
hdl/cache_pkg.sv
hdl/cache_store.sv
hdl/write_buffer.sv
hdl/cache_engine.sv
hdl/cache_control.sv
hdl/cache_top.sv
test/cache_checker.sv
test/cache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed!
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "make help   list the targets"
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || { echo "FAIL: see $(LOG)"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/cache_tb.sv ====
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_tb import cache_pkg::*; ();

   localparam int MEM_WORDS = 1 << `CACHE_ADDR_W;
   localparam int LINES     = 1 << `CACHE_INDEX_W;

   logic clk = 1'b0;
   logic reset;
   logic cpu_cyc;
   logic cpu_stb;
   logic cpu_we;
   addr_t cpu_adr;
   word_t cpu_dat_w;
   word_t cpu_dat_r;
   logic cpu_ack;
   logic ctrl_cyc;
   logic ctrl_stb;
   logic ctrl_we;
   logic [`CACHE_CTRL_ADDR_W-1:0] ctrl_adr;
   word_t ctrl_dat_r;
   logic ctrl_ack;
   logic mem_cyc;
   logic mem_stb;
   logic mem_we;
   addr_t mem_adr;
   word_t mem_dat_w;
   word_t mem_dat_r;
   logic mem_ack;

   // Main memory and the CPU writes it still expects, oldest first.
   word_t mem [MEM_WORDS];
   addr_t wr_adr_q [$];
   word_t wr_dat_q [$];

   // Operations from the golden file.
   byte   op_q [$];
   addr_t adr_q [$];
   word_t val_q [$];

   // Valid lines and counters as the cache should see them.
   logic [LINES-1:0] line_valid;
   logic [`CACHE_TAG_W-1:0] line_tag [LINES];
   int read_hits;
   int read_misses;
   int write_hits;
   int write_misses;

   int errors = 0;
   int checks = 0;
   int cycles = 0;
   int cycle_limit = 32'h7fff_ffff;
   int mem_wait = -1;
   logic [31:0] gap_lfsr = 32'h88a5;
   logic [31:0] mem_lfsr = 32'h88a5;

   cache_top cache_top_inst (.*);

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycles++;
      if (cycles > cycle_limit) begin
         $display("Timeout: run stopped after %0d cycles without the expected ack", cycle_limit);
         $display("Checks: %0d, errors: %0d", checks, errors + 1);
         $display("Test failures found");
         $finish;
      end
   end

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
   endfunction

   // Two bits, one step each, give 0 to 3.
   task automatic draw_delay(inout logic [31:0] s, output int v);
      v = 0;
      repeat (2) begin
         v = (v << 1) | int'(s[0]);
         s = lfsr_step(s);
      end
   endtask

   // Memory slave with random ack delay.
   always @(negedge clk) begin
      if (mem_ack) begin
         mem_ack = 1'b0;
      end else if (!reset && mem_cyc && mem_stb) begin
         if (mem_wait < 0) begin
            draw_delay(mem_lfsr, mem_wait);
         end
         if (mem_wait > 0) begin
            mem_wait--;
         end else begin
            mem_wait = -1;
            if (mem_we) begin
               if (wr_adr_q.size() == 0) begin
                  errors++;
                  $display("Memory write to %h arrived with no CPU write pending", mem_adr);
               end else begin
                  checks += 2;
                  if (mem_adr !== wr_adr_q[0]) begin
                     errors++;
                     $display("CHECK FAILED mem_adr: expected %h, got %h", wr_adr_q[0], mem_adr);
                  end
                  if (mem_dat_w !== wr_dat_q[0]) begin
                     errors++;
                     $display("CHECK FAILED mem_dat_w: expected %h, got %h",
                              wr_dat_q[0], mem_dat_w);
                  end
                  void'(wr_adr_q.pop_front());
                  void'(wr_dat_q.pop_front());
               end
               mem[mem_adr] = mem_dat_w;
            end else begin
               mem_dat_r = mem[mem_adr];
            end
            mem_ack = 1'b1;
         end
      end
   end

   task automatic cpu_access(input logic we, input addr_t a, input word_t d,
                             output word_t rdata, output int lat);
      cpu_cyc   = 1'b1;
      cpu_stb   = 1'b1;
      cpu_we    = we;
      cpu_adr   = a;
      cpu_dat_w = d;
      lat = 0;
      do begin
         @(negedge clk);
         lat++;
      end while (!cpu_ack);
      rdata = cpu_dat_r;
      // Strobe stays up through the ack cycle.
      @(negedge clk);
      cpu_cyc = 1'b0;
      cpu_stb = 1'b0;
      cpu_we  = 1'b0;
   endtask

   task automatic ctrl_access(input logic we, input logic [3:0] r,
                              output word_t rdata, output int lat);
      ctrl_cyc = 1'b1;
      ctrl_stb = 1'b1;
      ctrl_we  = we;
      ctrl_adr = r;
      lat = 0;
      do begin
         @(negedge clk);
         lat++;
      end while (!ctrl_ack);
      rdata = ctrl_dat_r;
      @(negedge clk);
      ctrl_cyc = 1'b0;
      ctrl_stb = 1'b0;
      ctrl_we  = 1'b0;
   endtask

   // Returns at a falling edge once memory has taken every write.
   task automatic wait_writes_done();
      do begin
         @(posedge clk);
      end while (wr_adr_q.size() != 0 || mem_ack);
      @(negedge clk);
   endtask

   function automatic word_t model_register(input logic [3:0] r);
      case (r)
         `CTRL_HIT:        return word_t'(read_hits + write_hits);
         `CTRL_MISS:       return word_t'(read_misses + write_misses);
         `CTRL_READ_HIT:   return word_t'(read_hits);
         `CTRL_READ_MISS:  return word_t'(read_misses);
         `CTRL_WRITE_HIT:  return word_t'(write_hits);
         `CTRL_WRITE_MISS: return word_t'(write_misses);
         `CTRL_BUF_EMPTY:  return 32'd1;
         `CTRL_VERSION:    return `CACHE_VERSION;
         default:          return 32'd0;
      endcase
   endfunction

   task automatic cpu_read(input addr_t a, input word_t expected);
      logic [`CACHE_INDEX_W-1:0] idx;
      logic [`CACHE_TAG_W-1:0] tag;
      logic predicted_hit;
      word_t got;
      int lat;
      idx = a[`CACHE_INDEX_W-1:0];
      tag = a[`CACHE_ADDR_W-1:`CACHE_INDEX_W];
      predicted_hit = line_valid[idx] && (line_tag[idx] == tag);
      cpu_access(1'b0, a, '0, got, lat);
      checks++;
      if (got !== expected) begin
         errors++;
         $display("CHECK FAILED cpu_dat_r at %h: expected %h, got %h", a, expected, got);
      end
      if (predicted_hit) begin
         read_hits++;
         checks++;
         if (lat != 1) begin
            errors++;
            $display("CHECK FAILED cpu_ack latency at %h: expected %h, got %h", a, 1, lat);
         end
      end else begin
         read_misses++;
         line_valid[idx] = 1'b1;
         line_tag[idx] = tag;
      end
   endtask

   task automatic cpu_write(input addr_t a, input word_t d);
      logic [`CACHE_INDEX_W-1:0] idx;
      logic [`CACHE_TAG_W-1:0] tag;
      logic predicted_hit;
      word_t unused;
      int lat;
      idx = a[`CACHE_INDEX_W-1:0];
      tag = a[`CACHE_ADDR_W-1:`CACHE_INDEX_W];
      predicted_hit = line_valid[idx] && (line_tag[idx] == tag);
      // Queued before the strobe so memory never sees it first.
      wr_adr_q.push_back(a);
      wr_dat_q.push_back(d);
      cpu_access(1'b1, a, d, unused, lat);
      if (predicted_hit) begin
         write_hits++;
      end else begin
         write_misses++;
      end
   endtask

   task automatic ctrl_read(input logic [3:0] r, input word_t expected);
      word_t got;
      word_t predicted;
      int lat;
      wait_writes_done();
      predicted = model_register(r);
      ctrl_access(1'b0, r, got, lat);
      checks += 3;
      if (lat != 1) begin
         errors++;
         $display("CHECK FAILED ctrl_ack latency: expected %h, got %h", 1, lat);
      end
      if (got !== expected) begin
         errors++;
         $display("CHECK FAILED ctrl_dat_r reg %h: expected %h, got %h", r, expected, got);
      end
      if (got !== predicted) begin
         errors++;
         $display("CHECK FAILED ctrl_dat_r reg %h model: expected %h, got %h",
                  r, predicted, got);
      end
   endtask

   task automatic ctrl_write(input logic [3:0] r);
      word_t unused;
      int lat;
      ctrl_access(1'b1, r, unused, lat);
      checks++;
      if (lat != 1) begin
         errors++;
         $display("CHECK FAILED ctrl_ack latency: expected %h, got %h", 1, lat);
      end
      if (r == `CTRL_RESET_CNT) begin
         read_hits    = 0;
         read_misses  = 0;
         write_hits   = 0;
         write_misses = 0;
      end else if (r == `CTRL_INVALIDATE) begin
         line_valid = '0;
      end
   endtask

   initial begin
      int fd;
      int n;
      int gap;
      string line;
      byte op;
      logic [31:0] a;
      logic [31:0] d;
      reset     = 1'b1;
      cpu_cyc   = 1'b0;
      cpu_stb   = 1'b0;
      cpu_we    = 1'b0;
      cpu_adr   = '0;
      cpu_dat_w = '0;
      ctrl_cyc  = 1'b0;
      ctrl_stb  = 1'b0;
      ctrl_we   = 1'b0;
      ctrl_adr  = '0;
      mem_dat_r = '0;
      mem_ack   = 1'b0;
      line_valid   = '0;
      read_hits    = 0;
      read_misses  = 0;
      write_hits   = 0;
      write_misses = 0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = {16'hc0de, i[15:0]};
      end

      fd = $fopen("test/cache_golden.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("Could not open test/cache_golden.txt");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) begin
               break;
            end
            n = $sscanf(line, "%c %h %h", op, a, d);
            if (n == 3 && op != "#") begin
               op_q.push_back(op);
               adr_q.push_back(addr_t'(a));
               val_q.push_back(d);
            end
         end
         $fclose(fd);
      end
      cycle_limit = op_q.size() * 40 + 100;

      repeat (8) @(negedge clk);
      reset = 1'b0;

      foreach (op_q[i]) begin
         draw_delay(gap_lfsr, gap);
         repeat (gap) @(negedge clk);
         case (op_q[i])
            "R": cpu_read(adr_q[i], val_q[i]);
            "W": cpu_write(adr_q[i], val_q[i]);
            "C": ctrl_read(adr_q[i][3:0], val_q[i]);
            "K": ctrl_write(adr_q[i][3:0]);
            default: begin
               errors++;
               $display("Unknown opcode %c in golden file", op_q[i]);
            end
         endcase
      end

      wait_writes_done();
      errors += cache_top_inst.cache_checker_inst.failures;
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// ==== test/cache_checker.sv ====
`timescale 1ns/1ps

module cache_checker import cache_pkg::*; (
   input logic  clk,
   input logic  reset,
   input logic  cpu_stb,
   input logic  cpu_ack,
   input logic  ctrl_cyc,
   input logic  ctrl_stb,
   input logic  ctrl_ack,
   input logic  mem_cyc,
   input logic  mem_stb,
   input logic  mem_we,
   input addr_t mem_adr,
   input word_t mem_dat_w,
   input logic  mem_ack
);

   int failures = 0;

   // CPU ack only inside a strobe.
   assert property (@(posedge clk) disable iff (reset) cpu_ack |-> cpu_stb)
      else begin
         $error("cpu_ack seen without cpu_stb");
         failures++;
      end

   // Control ack is one cycle after a new request.
   assert property (@(posedge clk) disable iff (reset)
      ctrl_cyc && ctrl_stb && !ctrl_ack |=> ctrl_ack)
      else begin
         $error("ctrl_ack missing one cycle after ctrl_stb");
         failures++;
      end

   assert property (@(posedge clk) disable iff (reset)
      ctrl_ack |-> $past(ctrl_cyc && ctrl_stb && !ctrl_ack))
      else begin
         $error("ctrl_ack without a preceding request");
         failures++;
      end

   // Strobe and cycle stay up until ack.
   assert property (@(posedge clk) disable iff (reset)
      mem_stb && !mem_ack |=> mem_stb && mem_cyc)
      else begin
         $error("mem_stb or mem_cyc dropped before mem_ack");
         failures++;
      end

   // Master holds the request until ack.
   assert property (@(posedge clk) disable iff (reset)
      mem_stb && !mem_ack |=> $stable(mem_adr) && $stable(mem_we) && $stable(mem_dat_w))
      else begin
         $error("memory request changed before mem_ack");
         failures++;
      end

endmodule

bind cache_top cache_checker cache_checker_inst (
   .clk       (clk),
   .reset     (reset),
   .cpu_stb   (cpu_stb),
   .cpu_ack   (cpu_ack),
   .ctrl_cyc  (ctrl_cyc),
   .ctrl_stb  (ctrl_stb),
   .ctrl_ack  (ctrl_ack),
   .mem_cyc   (mem_cyc),
   .mem_stb   (mem_stb),
   .mem_we    (mem_we),
   .mem_adr   (mem_adr),
   .mem_dat_w (mem_dat_w),
   .mem_ack   (mem_ack)
);

// ==== hdl/cache_top.sv ====
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_top (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          cpu_cyc,
   input  logic                          cpu_stb,
   input  logic                          cpu_we,
   input  logic [`CACHE_ADDR_W-1:0]      cpu_adr,
   input  logic [`CACHE_DATA_W-1:0]      cpu_dat_w,
   output logic [`CACHE_DATA_W-1:0]      cpu_dat_r,
   output logic                          cpu_ack,
   input  logic                          ctrl_cyc,
   input  logic                          ctrl_stb,
   input  logic                          ctrl_we,
   input  logic [`CACHE_CTRL_ADDR_W-1:0] ctrl_adr,
   output logic [`CACHE_DATA_W-1:0]      ctrl_dat_r,
   output logic                          ctrl_ack,
   output logic                          mem_cyc,
   output logic                          mem_stb,
   output logic                          mem_we,
   output logic [`CACHE_ADDR_W-1:0]      mem_adr,
   output logic [`CACHE_DATA_W-1:0]      mem_dat_w,
   input  logic [`CACHE_DATA_W-1:0]      mem_dat_r,
   input  logic                          mem_ack
);

   logic [`CACHE_INDEX_W-1:0] lookup_index;
   logic [`CACHE_TAG_W-1:0]   lookup_tag;
   logic                      hit;
   logic [`CACHE_DATA_W-1:0]  line_data;
   logic                      wr_en;
   logic [`CACHE_INDEX_W-1:0] wr_index;
   logic [`CACHE_TAG_W-1:0]   wr_tag;
   logic [`CACHE_DATA_W-1:0]  wr_data;

   logic                      buf_push;
   logic [`CACHE_ADDR_W-1:0]  buf_adr_in;
   logic [`CACHE_DATA_W-1:0]  buf_dat_in;
   logic                      buf_pop;
   logic                      buf_full;
   logic                      buf_empty;
   logic [`CACHE_ADDR_W-1:0]  buf_adr;
   logic [`CACHE_DATA_W-1:0]  buf_dat;

   logic                      read_hit;
   logic                      read_miss;
   logic                      write_hit;
   logic                      write_miss;
   logic                      invalidate;

   cache_store cache_store_inst (
      .clk          (clk),
      .reset        (reset),
      .invalidate   (invalidate),
      .lookup_index (lookup_index),
      .lookup_tag   (lookup_tag),
      .hit          (hit),
      .line_data    (line_data),
      .wr_en        (wr_en),
      .wr_index     (wr_index),
      .wr_tag       (wr_tag),
      .wr_data      (wr_data)
   );

   write_buffer write_buffer_inst (
      .clk    (clk),
      .reset  (reset),
      .push   (buf_push),
      .adr_in (buf_adr_in),
      .dat_in (buf_dat_in),
      .pop    (buf_pop),
      .full   (buf_full),
      .empty  (buf_empty),
      .adr    (buf_adr),
      .dat    (buf_dat)
   );

   cache_engine cache_engine_inst (
      .clk          (clk),
      .reset        (reset),
      .cpu_cyc      (cpu_cyc),
      .cpu_stb      (cpu_stb),
      .cpu_we       (cpu_we),
      .cpu_adr      (cpu_adr),
      .cpu_dat_w    (cpu_dat_w),
      .cpu_dat_r    (cpu_dat_r),
      .cpu_ack      (cpu_ack),
      .mem_cyc      (mem_cyc),
      .mem_stb      (mem_stb),
      .mem_we       (mem_we),
      .mem_adr      (mem_adr),
      .mem_dat_w    (mem_dat_w),
      .mem_dat_r    (mem_dat_r),
      .mem_ack      (mem_ack),
      .lookup_index (lookup_index),
      .lookup_tag   (lookup_tag),
      .hit          (hit),
      .line_data    (line_data),
      .wr_en        (wr_en),
      .wr_index     (wr_index),
      .wr_tag       (wr_tag),
      .wr_data      (wr_data),
      .buf_push     (buf_push),
      .buf_adr_in   (buf_adr_in),
      .buf_dat_in   (buf_dat_in),
      .buf_pop      (buf_pop),
      .buf_full     (buf_full),
      .buf_empty    (buf_empty),
      .buf_adr      (buf_adr),
      .buf_dat      (buf_dat),
      .read_hit     (read_hit),
      .read_miss    (read_miss),
      .write_hit    (write_hit),
      .write_miss   (write_miss)
   );

   cache_control cache_control_inst (
      .clk        (clk),
      .reset      (reset),
      .ctrl_cyc   (ctrl_cyc),
      .ctrl_stb   (ctrl_stb),
      .ctrl_we    (ctrl_we),
      .ctrl_adr   (ctrl_adr),
      .ctrl_dat_r (ctrl_dat_r),
      .ctrl_ack   (ctrl_ack),
      .read_hit   (read_hit),
      .read_miss  (read_miss),
      .write_hit  (write_hit),
      .write_miss (write_miss),
      .buf_full   (buf_full),
      .buf_empty  (buf_empty),
      .invalidate (invalidate)
   );

endmodule

// ==== hdl/cache_control.sv ====
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_control import cache_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       ctrl_cyc,
   input  logic       ctrl_stb,
   input  logic       ctrl_we,
   input  ctrl_addr_t ctrl_adr,
   output word_t      ctrl_dat_r,
   output logic       ctrl_ack,
   input  logic       read_hit,
   input  logic       read_miss,
   input  logic       write_hit,
   input  logic       write_miss,
   input  logic       buf_full,
   input  logic       buf_empty,
   output logic       invalidate
);

   word_t read_hit_cnt;
   word_t read_miss_cnt;
   word_t write_hit_cnt;
   word_t write_miss_cnt;
   word_t hit_cnt;
   word_t miss_cnt;
   logic  request;
   logic  counter_clear;

   assign request  = ctrl_cyc && ctrl_stb && !ctrl_ack;
   assign hit_cnt  = read_hit_cnt + write_hit_cnt;
   assign miss_cnt = read_miss_cnt + write_miss_cnt;

   // Command pulses line up with the ack.
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ctrl_ack      <= 1'b0;
         invalidate    <= 1'b0;
         counter_clear <= 1'b0;
      end else begin
         ctrl_ack      <= request;
         invalidate    <= request && ctrl_we && (ctrl_adr == `CTRL_INVALIDATE);
         counter_clear <= request && ctrl_we && (ctrl_adr == `CTRL_RESET_CNT);
      end
   end

   // Clear beats any event in the same cycle.
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         read_hit_cnt   <= '0;
         read_miss_cnt  <= '0;
         write_hit_cnt  <= '0;
         write_miss_cnt <= '0;
      end else if (counter_clear) begin
         read_hit_cnt   <= '0;
         read_miss_cnt  <= '0;
         write_hit_cnt  <= '0;
         write_miss_cnt <= '0;
      end else begin
         if (read_hit) begin
            read_hit_cnt <= read_hit_cnt + 1'b1;
         end
         if (read_miss) begin
            read_miss_cnt <= read_miss_cnt + 1'b1;
         end
         if (write_hit) begin
            write_hit_cnt <= write_hit_cnt + 1'b1;
         end
         if (write_miss) begin
            write_miss_cnt <= write_miss_cnt + 1'b1;
         end
      end
   end

   // Write-only and unmapped registers read as zero.
   always_ff @(posedge clk) begin
      ctrl_dat_r <= '0;
      if (request && !ctrl_we) begin
         case (ctrl_adr)
            `CTRL_HIT:        ctrl_dat_r <= hit_cnt;
            `CTRL_MISS:       ctrl_dat_r <= miss_cnt;
            `CTRL_READ_HIT:   ctrl_dat_r <= read_hit_cnt;
            `CTRL_READ_MISS:  ctrl_dat_r <= read_miss_cnt;
            `CTRL_WRITE_HIT:  ctrl_dat_r <= write_hit_cnt;
            `CTRL_WRITE_MISS: ctrl_dat_r <= write_miss_cnt;
            `CTRL_BUF_EMPTY:  ctrl_dat_r <= word_t'(buf_empty);
            `CTRL_BUF_FULL:   ctrl_dat_r <= word_t'(buf_full);
            `CTRL_VERSION:    ctrl_dat_r <= `CACHE_VERSION;
            default:          ctrl_dat_r <= '0;
         endcase
      end
   end

endmodule

// ==== hdl/cache_engine.sv ====
`timescale 1ns/1ps

module cache_engine import cache_pkg::*; (
   input  logic   clk,
   input  logic   reset,
   input  logic   cpu_cyc,
   input  logic   cpu_stb,
   input  logic   cpu_we,
   input  addr_t  cpu_adr,
   input  word_t  cpu_dat_w,
   output word_t  cpu_dat_r,
   output logic   cpu_ack,
   output logic   mem_cyc,
   output logic   mem_stb,
   output logic   mem_we,
   output addr_t  mem_adr,
   output word_t  mem_dat_w,
   input  word_t  mem_dat_r,
   input  logic   mem_ack,
   output index_t lookup_index,
   output tag_t   lookup_tag,
   input  logic   hit,
   input  word_t  line_data,
   output logic   wr_en,
   output index_t wr_index,
   output tag_t   wr_tag,
   output word_t  wr_data,
   output logic   buf_push,
   output addr_t  buf_adr_in,
   output word_t  buf_dat_in,
   output logic   buf_pop,
   input  logic   buf_full,
   input  logic   buf_empty,
   input  addr_t  buf_adr,
   input  word_t  buf_dat,
   output logic   read_hit,
   output logic   read_miss,
   output logic   write_hit,
   output logic   write_miss
);

   engine_state_t state;
   index_t        cpu_index;
   tag_t          cpu_tag;
   logic          request;
   logic          accept_read;
   logic          accept_write;
   logic          fill_done;
   logic          serve_buf;

   assign cpu_index = cpu_adr[$bits(index_t)-1:0];
   assign cpu_tag   = cpu_adr[$bits(addr_t)-1:$bits(index_t)];

   assign lookup_index = cpu_index;
   assign lookup_tag   = cpu_tag;

   // New accesses only in IDLE, never in their own ack cycle.
   assign request      = (state == IDLE) && cpu_cyc && cpu_stb && !cpu_ack;
   assign accept_read  = request && !cpu_we;
   // A write stalls here while the buffer is full.
   assign accept_write = request && cpu_we && !buf_full;

   assign read_hit   = accept_read && hit;
   assign read_miss  = accept_read && !hit;
   assign write_hit  = accept_write && hit;
   assign write_miss = accept_write && !hit;

   assign buf_push   = accept_write;
   assign buf_adr_in = cpu_adr;
   assign buf_dat_in = cpu_dat_w;

   // Line updates come from write hits and completed fills.
   assign fill_done = (state == FILL) && mem_ack;
   assign wr_en     = write_hit || fill_done;
   assign wr_index  = cpu_index;
   assign wr_tag    = cpu_tag;
   assign wr_data   = fill_done ? mem_dat_r : cpu_dat_w;

   // Buffer head owns the bus in IDLE and DRAIN, the fill read in FILL.
   assign serve_buf = (state == IDLE) || (state == DRAIN);
   assign mem_stb   = serve_buf ? !buf_empty : (state == FILL);
   assign mem_cyc   = mem_stb;
   assign mem_we    = serve_buf;
   assign mem_adr   = serve_buf ? buf_adr : cpu_adr;
   assign mem_dat_w = buf_dat;
   assign buf_pop   = serve_buf && !buf_empty && mem_ack;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state   <= IDLE;
         cpu_ack <= 1'b0;
      end else begin
         cpu_ack <= 1'b0;
         case (state)
            IDLE: begin
               if (read_hit || accept_write) begin
                  cpu_ack <= 1'b1;
               end else if (read_miss) begin
                  state <= DRAIN;
               end
            end
            DRAIN: begin
               // Memory must see every pending write before the fill.
               if (buf_empty) begin
                  state <= FILL;
               end
            end
            FILL: begin
               if (mem_ack) begin
                  state   <= RESPOND;
                  cpu_ack <= 1'b1;
               end
            end
            RESPOND: state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (read_hit) begin
         cpu_dat_r <= line_data;
      end else if (fill_done) begin
         cpu_dat_r <= mem_dat_r;
      end
   end

endmodule

// ==== hdl/write_buffer.sv ====
`timescale 1ns/1ps
`include "cache_cfg.svh"

module write_buffer import cache_pkg::*; (
   input  logic  clk,
   input  logic  reset,
   input  logic  push,
   input  addr_t adr_in,
   input  word_t dat_in,
   input  logic  pop,
   output logic  full,
   output logic  empty,
   output addr_t adr,
   output word_t dat
);

   localparam int DEPTH = `WTBUF_DEPTH;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   localparam logic [PTR_W-1:0] LAST_PTR  = PTR_W'(DEPTH - 1);
   localparam logic [PTR_W:0]   FULL_CNT  = (PTR_W + 1)'(DEPTH);

   addr_t            adr_mem [DEPTH];
   word_t            dat_mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;
   logic             do_push;
   logic             do_pop;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
   endfunction

   assign do_push = push && !full;
   assign do_pop  = pop && !empty;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         // Simultaneous push and pop keep the count.
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         adr_mem[wr_ptr] <= adr_in;
         dat_mem[wr_ptr] <= dat_in;
      end
   end

   assign full  = (count == FULL_CNT);
   assign empty = (count == '0);
   assign adr   = adr_mem[rd_ptr];
   assign dat   = dat_mem[rd_ptr];

endmodule

// ==== hdl/cache_store.sv ====
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_store import cache_pkg::*; (
   input  logic   clk,
   input  logic   reset,
   input  logic   invalidate,
   input  index_t lookup_index,
   input  tag_t   lookup_tag,
   output logic   hit,
   output word_t  line_data,
   input  logic   wr_en,
   input  index_t wr_index,
   input  tag_t   wr_tag,
   input  word_t  wr_data
);

   localparam int LINES = 1 << `CACHE_INDEX_W;

   logic [LINES-1:0] valid;
   tag_t             tag_mem  [LINES];
   word_t            data_mem [LINES];

   // Invalidate wins over a line write in the same cycle.
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         valid <= '0;
      end else if (invalidate) begin
         valid <= '0;
      end else if (wr_en) begin
         valid[wr_index] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         tag_mem[wr_index]  <= wr_tag;
         data_mem[wr_index] <= wr_data;
      end
   end

   // Lookup is purely combinational.
   assign hit       = valid[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
   assign line_data = data_mem[lookup_index];

endmodule

// ==== hdl/cache_pkg.sv ====
`include "cache_cfg.svh"

package cache_pkg;

   // Data word and word address.
   typedef logic [`CACHE_DATA_W-1:0]      word_t;
   typedef logic [`CACHE_ADDR_W-1:0]      addr_t;

   // Address split into line index and tag.
   typedef logic [`CACHE_INDEX_W-1:0]     index_t;
   typedef logic [`CACHE_TAG_W-1:0]       tag_t;

   // Control register address.
   typedef logic [`CACHE_CTRL_ADDR_W-1:0] ctrl_addr_t;

   typedef enum logic [1:0] {
      IDLE,
      DRAIN,
      FILL,
      RESPOND
   } engine_state_t;

endpackage

// ==== hdl/cache_cfg.svh ====
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// Datapath widths.
`define CACHE_DATA_W       32
`define CACHE_ADDR_W       16
`define CACHE_INDEX_W      6
`define CACHE_TAG_W        (`CACHE_ADDR_W - `CACHE_INDEX_W)
`define CACHE_CTRL_ADDR_W  4

// Entries in the write buffer.
`define WTBUF_DEPTH        4

// Control register map.
`define CTRL_HIT           4'd0
`define CTRL_MISS          4'd1
`define CTRL_READ_HIT      4'd2
`define CTRL_READ_MISS     4'd3
`define CTRL_WRITE_HIT     4'd4
`define CTRL_WRITE_MISS    4'd5
`define CTRL_BUF_EMPTY     4'd6
`define CTRL_BUF_FULL      4'd7
`define CTRL_VERSION       4'd8
`define CTRL_RESET_CNT     4'd9
`define CTRL_INVALIDATE    4'd10

// Returned by CTRL_VERSION.
`define CACHE_VERSION      32'h0001_0300

`endif
